// ==== common/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and pc width
`define XLEN 32

// register file geometry
`define REG_ADDR_W 5
`define REG_COUNT 32

// cycles a mul spends in execute, must divide XLEN
`define MUL_CYCLES 4

`endif

// ==== common/isa_pkg.sv ====
package isa_pkg;

    // major opcodes, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'h00,
        OP_ADDIU    = 6'h09,
        OP_LUI      = 6'h0f,
        OP_SPECIAL2 = 6'h1c
    } opcode_e;

    // function field, inst[5:0]
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_MUL  = 6'h02,  // only under SPECIAL2
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a
    } funct_e;

    // internal operation carried to execute
    typedef enum logic [3:0] {
        ALU_ADDU,
        ALU_SUBU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_MUL,
        ALU_ADDIU,
        ALU_LUI
    } alu_op_e;

endpackage

// ==== common/pipe_pkg.sv ====
package pipe_pkg;

`include "cpu_params.svh"

    typedef struct packed {
        logic [`XLEN-1:0]         pc;
        isa_pkg::alu_op_e         alu_op;
        logic [`XLEN-1:0]         src1;
        logic [`XLEN-1:0]         src2;   // rt value or expanded immediate
        logic [$clog2(`XLEN)-1:0] sa;
        logic [`REG_ADDR_W-1:0]   dest;
    } ds_to_es_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`XLEN-1:0]       result;
    } es_to_ws_t;

    // bypass source seen by decode
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`XLEN-1:0]       result;
        logic                   ready;  // result is final
    } fwd_t;

    typedef struct packed {
        logic                   wen;
        logic [`REG_ADDR_W-1:0] waddr;
        logic [`XLEN-1:0]       wdata;
    } rf_write_t;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [3:0]             wen;
        logic [`REG_ADDR_W-1:0] wnum;
        logic [`XLEN-1:0]       wdata;
    } trace_t;

endpackage

// ==== decode/regfile.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module regfile (
    input  logic                   aclk,
    input  logic [`REG_ADDR_W-1:0] raddr1,
    input  logic [`REG_ADDR_W-1:0] raddr2,
    output logic [`XLEN-1:0]       rdata1,
    output logic [`XLEN-1:0]       rdata2,
    input  pipe_pkg::rf_write_t    wr
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge aclk) begin
        if (wr.wen && wr.waddr != '0) begin
            regs[wr.waddr] <= wr.wdata;
        end
    end

    // write-first, $0 hardwired
    always_comb begin
        if (raddr1 == '0)
            rdata1 = '0;
        else if (wr.wen && wr.waddr == raddr1)
            rdata1 = wr.wdata;
        else
            rdata1 = regs[raddr1];

        if (raddr2 == '0)
            rdata2 = '0;
        else if (wr.wen && wr.waddr == raddr2)
            rdata2 = wr.wdata;
        else
            rdata2 = regs[raddr2];
    end

endmodule

// ==== execute/mul_unit.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

// shift-add multiplier, XLEN/MUL_CYCLES multiplier bits per cycle
module mul_unit (
    input  logic             aclk,
    input  logic             rst,
    input  logic             start,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    output logic             done,
    output logic [`XLEN-1:0] product
);

    localparam int CH    = `XLEN / `MUL_CYCLES;
    localparam int CNT_W = $clog2(`MUL_CYCLES + 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    logic [`XLEN-1:0] acc;
    logic [`XLEN-1:0] acc_base;
    logic [CH-1:0]    b_chunk;
    logic [`XLEN-1:0] partial;

    // a and b stay stable while the owning stage holds its record
    assign b_chunk  = b[count*CH +: CH];
    assign partial  = (a * b_chunk) << (count * CH);
    assign acc_base = busy ? acc : '0;

    // last chunk is added combinationally
    assign done    = (start || busy) && count == CNT_W'(`MUL_CYCLES - 1);
    assign product = acc_base + partial;

    always_ff @(posedge aclk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (done) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (start || busy) begin
            busy  <= 1'b1;
            count <= count + 1'b1;
        end
        if (start || busy) begin
            acc <= product;
        end
    end

endmodule

// ==== decode/id_stage.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module id_stage (
    input  logic                aclk,
    input  logic                rst,
    input  logic                inst_valid,
    input  logic [`XLEN-1:0]    inst_pc,
    input  logic [`XLEN-1:0]    inst_word,
    output logic                inst_ready,
    input  logic                es_allowin,
    input  pipe_pkg::fwd_t      es_fwd,
    input  pipe_pkg::fwd_t      ws_fwd,
    input  pipe_pkg::rf_write_t rf_wr,
    output logic                ds_to_es_valid,
    output pipe_pkg::ds_to_es_t ds_to_es_bus
);

    logic                   ds_valid;
    logic                   ds_allowin;
    logic                   ds_ready_go;
    logic [`XLEN-1:0]       ds_pc;
    logic [`XLEN-1:0]       ds_inst;
    isa_pkg::opcode_e       opcode;
    isa_pkg::funct_e        funct;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rf_rdata1;
    logic [`XLEN-1:0]       rf_rdata2;
    logic [`XLEN-1:0]       rs_value;
    logic [`XLEN-1:0]       rt_value;
    isa_pkg::alu_op_e       alu_op;
    logic [`REG_ADDR_W-1:0] dest;
    logic                   uses_rs;
    logic                   uses_rt;
    logic                   use_imm;
    logic [`XLEN-1:0]       imm_value;

    // execute first, then write-back, then the array
    function automatic logic [`XLEN-1:0] pick_operand(
        input logic [`REG_ADDR_W-1:0] src,
        input logic [`XLEN-1:0]       rf_value,
        input pipe_pkg::fwd_t         es,
        input pipe_pkg::fwd_t         ws
    );
        if (src != '0 && es.valid && es.dest == src)
            return es.result;
        if (src != '0 && ws.valid && ws.dest == src)
            return ws.result;
        return rf_value;
    endfunction

    assign ds_allowin  = !ds_valid || (ds_ready_go && es_allowin);
    assign inst_ready  = ds_allowin;

    always_ff @(posedge aclk) begin
        if (rst) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= inst_valid;
        end
        if (inst_valid && ds_allowin) begin
            ds_pc   <= inst_pc;
            ds_inst <= inst_word;
        end
    end

    assign opcode = isa_pkg::opcode_e'(ds_inst[31:26]);
    assign funct  = isa_pkg::funct_e'(ds_inst[5:0]);
    assign rs     = ds_inst[25:21];
    assign rt     = ds_inst[20:16];
    assign rd     = ds_inst[15:11];

    always_comb begin
        alu_op    = isa_pkg::ALU_ADDU;
        dest      = '0;     // unknown words retire into $0
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        use_imm   = 1'b0;
        imm_value = '0;
        case (opcode)
            isa_pkg::OP_SPECIAL: begin
                dest    = rd;
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                case (funct)
                    isa_pkg::F_ADDU: alu_op = isa_pkg::ALU_ADDU;
                    isa_pkg::F_SUBU: alu_op = isa_pkg::ALU_SUBU;
                    isa_pkg::F_AND:  alu_op = isa_pkg::ALU_AND;
                    isa_pkg::F_OR:   alu_op = isa_pkg::ALU_OR;
                    isa_pkg::F_XOR:  alu_op = isa_pkg::ALU_XOR;
                    isa_pkg::F_SLT:  alu_op = isa_pkg::ALU_SLT;
                    isa_pkg::F_SLL: begin
                        alu_op  = isa_pkg::ALU_SLL;
                        uses_rs = 1'b0;
                    end
                    default: dest = '0;
                endcase
            end
            isa_pkg::OP_SPECIAL2: begin
                if (funct == isa_pkg::F_MUL) begin
                    alu_op  = isa_pkg::ALU_MUL;
                    dest    = rd;
                    uses_rs = 1'b1;
                    uses_rt = 1'b1;
                end
            end
            isa_pkg::OP_ADDIU: begin
                alu_op    = isa_pkg::ALU_ADDIU;
                dest      = rt;
                uses_rs   = 1'b1;
                use_imm   = 1'b1;
                imm_value = {{(`XLEN-16){ds_inst[15]}}, ds_inst[15:0]};
            end
            isa_pkg::OP_LUI: begin
                alu_op    = isa_pkg::ALU_LUI;
                dest      = rt;
                use_imm   = 1'b1;
                imm_value = {ds_inst[15:0], {(`XLEN-16){1'b0}}};
            end
            default: ;
        endcase
    end

    regfile u_regfile (
        .aclk   (aclk),
        .raddr1 (rs),
        .raddr2 (rt),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2),
        .wr     (rf_wr)
    );

    assign rs_value = pick_operand(rs, rf_rdata1, es_fwd, ws_fwd);
    assign rt_value = pick_operand(rt, rf_rdata2, es_fwd, ws_fwd);

    // wait for a mul that has not finished yet
    assign ds_ready_go = !(es_fwd.valid && !es_fwd.ready && es_fwd.dest != '0 &&
                           ((uses_rs && es_fwd.dest == rs) || (uses_rt && es_fwd.dest == rt)));

    assign ds_to_es_valid = ds_valid && ds_ready_go;

    always_comb begin
        ds_to_es_bus.pc     = ds_pc;
        ds_to_es_bus.alu_op = alu_op;
        ds_to_es_bus.src1   = rs_value;
        ds_to_es_bus.src2   = use_imm ? imm_value : rt_value;
        ds_to_es_bus.sa     = ds_inst[10:6];
        ds_to_es_bus.dest   = dest;
    end

endmodule

// ==== execute/exe_stage.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module exe_stage (
    input  logic                aclk,
    input  logic                rst,
    input  logic                ds_to_es_valid,
    input  pipe_pkg::ds_to_es_t ds_to_es_bus,
    output logic                es_allowin,
    input  logic                ws_allowin,
    output logic                es_to_ws_valid,
    output pipe_pkg::es_to_ws_t es_to_ws_bus,
    output pipe_pkg::fwd_t      es_fwd
);

    logic                es_valid;
    pipe_pkg::ds_to_es_t es_rec;
    logic                es_ready_go;
    logic                is_mul;
    logic                mul_started;
    logic                mul_start;
    logic                mul_done;
    logic [`XLEN-1:0]    mul_product;
    logic [`XLEN-1:0]    alu_result;
    logic [`XLEN-1:0]    es_result;

    assign es_allowin = !es_valid || (es_ready_go && ws_allowin);

    always_ff @(posedge aclk) begin
        if (rst) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds_to_es_valid;
        end
        if (ds_to_es_valid && es_allowin) begin
            es_rec <= ds_to_es_bus;
        end
    end

    always_comb begin
        case (es_rec.alu_op)
            isa_pkg::ALU_ADDU,
            isa_pkg::ALU_ADDIU: alu_result = es_rec.src1 + es_rec.src2;
            isa_pkg::ALU_SUBU:  alu_result = es_rec.src1 - es_rec.src2;
            isa_pkg::ALU_AND:   alu_result = es_rec.src1 & es_rec.src2;
            isa_pkg::ALU_OR:    alu_result = es_rec.src1 | es_rec.src2;
            isa_pkg::ALU_XOR:   alu_result = es_rec.src1 ^ es_rec.src2;
            isa_pkg::ALU_SLT:
                alu_result = {{(`XLEN-1){1'b0}}, $signed(es_rec.src1) < $signed(es_rec.src2)};
            isa_pkg::ALU_SLL:   alu_result = es_rec.src2 << es_rec.sa;
            isa_pkg::ALU_LUI:   alu_result = es_rec.src2;  // already shifted in decode
            default:            alu_result = '0;
        endcase
    end

    assign is_mul    = es_rec.alu_op == isa_pkg::ALU_MUL;
    assign mul_start = es_valid && is_mul && !mul_started;  // one start per mul

    always_ff @(posedge aclk) begin
        if (rst) begin
            mul_started <= 1'b0;
        end else if (mul_done) begin
            mul_started <= 1'b0;
        end else if (mul_start) begin
            mul_started <= 1'b1;
        end
    end

    mul_unit u_mul_unit (
        .aclk    (aclk),
        .rst     (rst),
        .start   (mul_start),
        .a       (es_rec.src1),
        .b       (es_rec.src2),
        .done    (mul_done),
        .product (mul_product)
    );

    assign es_ready_go = !is_mul || mul_done;
    assign es_result   = is_mul ? mul_product : alu_result;

    assign es_to_ws_valid = es_valid && es_ready_go;

    always_comb begin
        es_to_ws_bus.pc     = es_rec.pc;
        es_to_ws_bus.dest   = es_rec.dest;
        es_to_ws_bus.result = es_result;

        es_fwd.valid  = es_valid;
        es_fwd.dest   = es_rec.dest;
        es_fwd.result = es_result;
        es_fwd.ready  = es_ready_go;  // low while mul runs
    end

endmodule

// ==== logic/wb_stage.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module wb_stage (
    input  logic                aclk,
    input  logic                rst,
    input  logic                es_to_ws_valid,
    input  pipe_pkg::es_to_ws_t es_to_ws_bus,
    output logic                ws_allowin,
    output pipe_pkg::rf_write_t rf_wr,
    output pipe_pkg::fwd_t      ws_fwd,
    output pipe_pkg::trace_t    trace
);

    logic                ws_valid;
    pipe_pkg::es_to_ws_t ws_rec;
    logic                ws_wen;

    assign ws_allowin = 1'b1;  // retires every cycle

    always_ff @(posedge aclk) begin
        if (rst) begin
            ws_valid <= 1'b0;
        end else begin
            ws_valid <= es_to_ws_valid;
        end
        if (es_to_ws_valid) begin
            ws_rec <= es_to_ws_bus;
        end
    end

    assign ws_wen = ws_valid && ws_rec.dest != '0;

    always_comb begin
        rf_wr.wen   = ws_wen;
        rf_wr.waddr = ws_rec.dest;
        rf_wr.wdata = ws_rec.result;

        ws_fwd.valid  = ws_valid;
        ws_fwd.dest   = ws_rec.dest;
        ws_fwd.result = ws_rec.result;
        ws_fwd.ready  = 1'b1;

        trace.valid = ws_valid;
        trace.pc    = ws_rec.pc;
        trace.wen   = {4{ws_wen}};     // $0 writes still show wdata
        trace.wnum  = ws_rec.dest;
        trace.wdata = ws_rec.result;
    end

endmodule

// ==== logic/cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_core (
    input  logic                   aclk,
    input  logic                   rst,
    input  logic                   inst_valid,
    input  logic [`XLEN-1:0]       inst_pc,
    input  logic [`XLEN-1:0]       inst_word,
    output logic                   inst_ready,
    output logic                   debug_wb_valid,
    output logic [`XLEN-1:0]       debug_wb_pc,
    output logic [3:0]             debug_wb_rf_wen,
    output logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum,
    output logic [`XLEN-1:0]       debug_wb_rf_wdata
);

    logic                es_allowin;
    logic                ws_allowin;
    logic                ds_to_es_valid;
    logic                es_to_ws_valid;
    pipe_pkg::ds_to_es_t ds_to_es_bus;
    pipe_pkg::es_to_ws_t es_to_ws_bus;
    pipe_pkg::fwd_t      es_fwd;
    pipe_pkg::fwd_t      ws_fwd;
    pipe_pkg::rf_write_t rf_wr;
    pipe_pkg::trace_t    trace;

    id_stage u_id_stage (
        .aclk           (aclk),
        .rst            (rst),
        .inst_valid     (inst_valid),
        .inst_pc        (inst_pc),
        .inst_word      (inst_word),
        .inst_ready     (inst_ready),
        .es_allowin     (es_allowin),
        .es_fwd         (es_fwd),
        .ws_fwd         (ws_fwd),
        .rf_wr          (rf_wr),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus)
    );

    exe_stage u_exe_stage (
        .aclk           (aclk),
        .rst            (rst),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .es_allowin     (es_allowin),
        .ws_allowin     (ws_allowin),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws_bus   (es_to_ws_bus),
        .es_fwd         (es_fwd)
    );

    wb_stage u_wb_stage (
        .aclk           (aclk),
        .rst            (rst),
        .es_to_ws_valid (es_to_ws_valid),
        .es_to_ws_bus   (es_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .rf_wr          (rf_wr),
        .ws_fwd         (ws_fwd),
        .trace          (trace)
    );

    // trace port
    assign debug_wb_valid    = trace.valid;
    assign debug_wb_pc       = trace.pc;
    assign debug_wb_rf_wen   = trace.wen;
    assign debug_wb_rf_wnum  = trace.wnum;
    assign debug_wb_rf_wdata = trace.wdata;

endmodule

// ==== bench/tb_cpu_core.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu_core;

    localparam int MAX_VEC = 64;

    logic                   aclk;
    logic                   rst;
    logic                   inst_valid;
    logic [`XLEN-1:0]       inst_pc;
    logic [`XLEN-1:0]       inst_word;
    logic                   inst_ready;
    logic                   debug_wb_valid;
    logic [`XLEN-1:0]       debug_wb_pc;
    logic [3:0]             debug_wb_rf_wen;
    logic [`REG_ADDR_W-1:0] debug_wb_rf_wnum;
    logic [`XLEN-1:0]       debug_wb_rf_wdata;

    // four words per vector: pc, inst, wnum, wdata
    logic [`XLEN-1:0] vec_mem [0:4*MAX_VEC-1];
    int               n_vec;
    int               n_checked;
    logic             checking;
    logic             ready_dropped;  // seen while a mul holds execute
    logic [31:0]      rng_state;

    cpu_core dut_i (
        .aclk              (aclk),
        .rst               (rst),
        .inst_valid        (inst_valid),
        .inst_pc           (inst_pc),
        .inst_word         (inst_word),
        .inst_ready        (inst_ready),
        .debug_wb_valid    (debug_wb_valid),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_pc(input string name, input pipe_pkg::trace_t exp,
                            input pipe_pkg::trace_t act);
        if (act.pc !== exp.pc)
            stop_on_error($sformatf("mismatch %s pc: expected %h, actual %h",
                                    name, exp.pc, act.pc));
    endtask

    task automatic check_wen(input string name, input pipe_pkg::trace_t exp,
                             input pipe_pkg::trace_t act);
        if (act.wen !== exp.wen)
            stop_on_error($sformatf("mismatch %s wen: expected %h, actual %h",
                                    name, exp.wen, act.wen));
    endtask

    task automatic check_wnum(input string name, input pipe_pkg::trace_t exp,
                              input pipe_pkg::trace_t act);
        if (act.wnum !== exp.wnum)
            stop_on_error($sformatf("mismatch %s wnum: expected %0d, actual %0d",
                                    name, exp.wnum, act.wnum));
    endtask

    task automatic check_wdata(input string name, input pipe_pkg::trace_t exp,
                               input pipe_pkg::trace_t act);
        if (act.wdata !== exp.wdata)
            stop_on_error($sformatf("mismatch %s wdata: expected %h, actual %h",
                                    name, exp.wdata, act.wdata));
    endtask

    // one negedge sample of the trace port
    task automatic check_cycle();
        pipe_pkg::trace_t exp;
        pipe_pkg::trace_t act;
        string            name;
        act.valid = debug_wb_valid;
        act.pc    = debug_wb_pc;
        act.wen   = debug_wb_rf_wen;
        act.wnum  = debug_wb_rf_wnum;
        act.wdata = debug_wb_rf_wdata;
        exp       = '0;
        if ($isunknown(act.valid))
            stop_on_error("debug_wb_valid is unknown after reset");
        if (!inst_ready)
            ready_dropped = 1'b1;
        if (!act.valid) begin
            check_wen("idle cycle", exp, act);
        end else begin
            if (n_checked >= n_vec)
                stop_on_error("a trace appeared after every expected record was seen");
            name      = $sformatf("vector %0d", n_checked);
            exp.valid = 1'b1;
            exp.pc    = vec_mem[4*n_checked];
            exp.wnum  = vec_mem[4*n_checked+2][`REG_ADDR_W-1:0];
            exp.wdata = vec_mem[4*n_checked+3];
            exp.wen   = (exp.wnum == '0) ? 4'h0 : 4'hf;  // $0 never written
            check_pc(name, exp, act);
            check_wen(name, exp, act);
            check_wnum(name, exp, act);
            check_wdata(name, exp, act);
            n_checked++;
        end
    endtask

    always @(negedge aclk) begin
        if (checking)
            check_cycle();
    end

    task automatic drive_stream();
        int idx;
        int gap;
        idx = 0;
        while (idx < n_vec) begin
            inst_valid = 1'b1;
            inst_pc    = vec_mem[4*idx];
            inst_word  = vec_mem[4*idx+1];
            while (!inst_ready)
                @(negedge aclk);
            @(negedge aclk);  // taken at the edge in between
            rng_state  = xorshift32(rng_state);
            gap        = rng_state % 3;
            inst_valid = 1'b0;
            repeat (gap) @(negedge aclk);
            idx++;
        end
        inst_valid = 1'b0;
    endtask

    initial begin : main
        rst           = 1'b1;
        inst_valid    = 1'b0;
        inst_pc       = '0;
        inst_word     = '0;
        checking      = 1'b0;
        ready_dropped = 1'b0;
        n_checked     = 0;
        n_vec         = 0;
        rng_state     = 32'd6;
        $readmemh("bench/cpu_vectors.txt", vec_mem);
        while (n_vec < MAX_VEC && !$isunknown(vec_mem[4*n_vec]))
            n_vec++;
        if (n_vec == 0)
            stop_on_error("no vectors could be read from bench/cpu_vectors.txt");
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        if (inst_ready !== 1'b1)
            stop_on_error("inst_ready is not high after reset");
        @(posedge aclk);
        checking = 1'b1;
        @(negedge aclk);
        drive_stream();
        wait (n_checked == n_vec);
        repeat (`MUL_CYCLES + 4) @(negedge aclk);  // catch stray traces
        if (ready_dropped) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            stop_on_error("inst_ready never dropped while a mul was running");
        end
    end

    initial begin : watchdog
        wait (n_vec > 0);
        repeat (n_vec * (`MUL_CYCLES + 6) + 50) @(posedge aclk);
        stop_on_error("timeout, traces stopped arriving before all vectors retired");
    end

endmodule

// ==== bench/cpu_vectors.txt ====
// columns: pc  inst_word  expected_wnum  expected_wdata (hex)
// expected wen is all ones unless wnum is zero
bfc00000 3c011234 01 12340000
bfc00004 24215678 01 12345678
bfc00008 2402ffff 02 ffffffff
bfc0000c 00221821 03 12345677
bfc00010 00012023 04 edcba988
bfc00014 00242824 05 00000008
bfc00018 00a33025 06 1234567f
bfc0001c 00c23826 07 edcba980
bfc00020 00e1402a 08 00000001
bfc00024 0027482a 09 00000000
bfc00028 000857c0 0a 80000000
bfc0002c 00015900 0b 23456780
bfc00030 240c0007 0c 00000007
bfc00034 240dfffd 0d fffffffd
bfc00038 718d7002 0e ffffffeb
bfc0003c 01cc7821 0f fffffff2
bfc00040 706c8002 10 7f6e5d41
bfc00044 720d8802 11 81b4e83d
bfc00048 02309023 12 02468afc
bfc0004c 24000055 00 00000055
bfc00050 00019821 13 12345678
bfc00054 00220025 00 ffffffff
bfc00058 000da026 14 fffffffd
bfc0005c 3c158000 15 80000000
bfc00060 02a0b02a 16 00000001
bfc00064 72b5b802 17 00000000
bfc00068 26f87fff 18 00007fff

// ==== flist.f ====
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
decode/regfile.sv
execute/mul_unit.sv
decode/id_stage.sv
execute/exe_stage.sv
logic/wb_stage.sv
logic/cpu_core.sv
bench/tb_cpu_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

export_include_dirs:
  - common

sources:
  - common/isa_pkg.sv
  - common/pipe_pkg.sv
  - decode/regfile.sv
  - execute/mul_unit.sv
  - decode/id_stage.sv
  - execute/exe_stage.sv
  - logic/wb_stage.sv
  - logic/cpu_core.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/tb_cpu_core.sv
